//--- all.f
hdl/memPkg.sv
hdl/memReg.sv
hdl/storeAlign.sv
hdl/dataRam.sv
hdl/excUnit.sv
hdl/loadExtend.sv
hdl/memTop.sv
bench/tbMem.sv

//--- bench/tbMem.sv
/*
 * random testbench for memTop, stops at the first mismatch
 * loads only touch a small preloaded address window, so RAM reads are never undefined
 */
`timescale 1ns/1ps

module tbMem;
    localparam int          RAM_WORDS  = 256;
    localparam logic [31:0] EXC_VECTOR = 32'hBFC00380;
    localparam int          PERIOD     = 8;
    localparam int          IDX_W      = $clog2(RAM_WORDS);
    localparam logic [31:0] WIN_BASE   = 32'h100;   // words 64..71
    localparam int          WIN_WORDS  = 8;
    localparam int          NUM_RAND   = 600;
    localparam int          TOTAL_CYC  = 3 + WIN_WORDS + NUM_RAND + 4;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    typedef struct packed {
        logic             valid;
        logic             flush;
        logic [31:0]      pc;
        logic [31:0]      addr;
        logic [31:0]      sdata;
        memPkg::loadKind  ld;
        memPkg::storeKind st;
        memPkg::wbSel     sel;
        logic             cp0Sel;
        logic [4:0]       dst;
        logic             regWr;
        memPkg::exeEvent  ev;
    } stimRec;

    logic clk, rstN, inValid, inCp0Sel, inRegWr, memFlush;
    logic [31:0] inPc, inAluOut, inStoreData;
    logic [4:0] inDst;
    memPkg::loadKind inLoad;
    memPkg::storeKind inStore;
    memPkg::wbSel inWbSel;
    memPkg::exeEvent inEvent;
    logic wbValid, redirValid;
    logic [4:0] wbDst;
    logic [31:0] wbData, redirPc;
    memPkg::excCode redirCode;

    // reference model state
    logic [31:0] modelRam [RAM_WORDS];
    logic [31:0] epc, badVAddr, lfsr;
    logic exl, checking;
    stimRec nxt, cur, s1;   // next drive, driven now, held in stage 1
    int cyc;
    int wbDueQ[$];
    logic [4:0] wbDstQ[$];
    logic [31:0] wbDataQ[$];
    int redirDueQ[$];
    logic [31:0] redirPcQ[$];
    memPkg::excCode redirCodeQ[$];

    memTop #(.RAM_WORDS(RAM_WORDS), .EXC_VECTOR(EXC_VECTOR)) u_dut (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inPc(inPc), .inAluOut(inAluOut),
        .inStoreData(inStoreData), .inLoad(inLoad), .inStore(inStore), .inWbSel(inWbSel),
        .inCp0Sel(inCp0Sel), .inDst(inDst), .inRegWr(inRegWr), .inEvent(inEvent),
        .memFlush(memFlush), .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData),
        .redirValid(redirValid), .redirPc(redirPc), .redirCode(redirCode)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TOTAL_CYC + 50) * PERIOD);
        abortRun("timeout: the run did not finish in the expected time");
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    // one LFSR step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] makeAddr(input int align);
        logic [31:0] hi;
        logic [31:0] off;
        logic [31:0] a;
        hi = randBits(2);
        off = randBits(5);
        a = (hi << 10) | WIN_BASE | off;   // bits 11:10 alias the same RAM word
        if (randBits(2) != 0) a = a & ~32'(align - 1);   // mostly aligned
        return a;
    endfunction

    task automatic genInstr();
        logic [3:0] op;
        logic [2:0] k;
        op = 4'(randBits(4));
        nxt = '0;
        nxt.valid = 1'b1;
        nxt.pc = randBits(30) << 2;
        nxt.dst = 5'(randBits(5));
        nxt.sdata = randBits(32);
        nxt.cp0Sel = 1'(randBits(1));
        case (op)
            4'd0, 4'd1, 4'd2, 4'd3: begin
                k = 3'(randBits(2));
                if (k == 3'd0) k = 3'd3;
                nxt.st = memPkg::storeKind'(k[1:0]);
                nxt.addr = makeAddr(k == 3'd1 ? 1 : (k == 3'd2 ? 2 : 4));
            end
            4'd4, 4'd5, 4'd6, 4'd7: begin
                k = 3'(randBits(3));
                if (k == 3'd0 || k > 3'd5) k = 3'd5;   // LW
                nxt.ld = memPkg::loadKind'(k);
                nxt.addr = makeAddr(k <= 3'd2 ? 1 : (k <= 3'd4 ? 2 : 4));
                nxt.sel = memPkg::WB_LOAD;
                nxt.regWr = 1'b1;
            end
            4'd8, 4'd9: begin
                nxt.addr = randBits(32);
                nxt.regWr = 1'(randBits(1));
            end
            4'd10: begin
                nxt.sel = memPkg::WB_LINK;
                nxt.regWr = 1'b1;
            end
            4'd11: begin
                nxt.sel = memPkg::WB_CP0;
                nxt.regWr = 1'b1;
            end
            4'd12, 4'd13: begin
                // overflow or syscall, often with a misaligned access too
                nxt.ev = (op == 4'd12) ? memPkg::EV_OV : memPkg::EV_SYS;
                if (randBits(1) != 0) nxt.ld = memPkg::LW;
                else nxt.st = memPkg::SW;
                nxt.addr = makeAddr(1);
                nxt.regWr = 1'(randBits(1));
            end
            4'd14: nxt.ev = memPkg::EV_ERET;
            default: nxt.valid = 1'b0;
        endcase
        nxt.flush = (randBits(4) == 0);
    endtask

    task automatic modelExec();
        logic [IDX_W-1:0] idx;
        logic [31:0] word;
        logic [31:0] val;
        logic [31:0] cp0Val;
        logic [7:0] b;
        logic [15:0] h;
        memPkg::excCode cause;
        idx = IDX_W'((s1.addr >> 2) % RAM_WORDS);
        word = modelRam[idx];
        cp0Val = s1.cp0Sel ? badVAddr : epc;
        b = 8'(word >> (8 * s1.addr[1:0]));   // little-endian lane
        h = 16'(word >> (16 * s1.addr[1]));
        if (s1.ev == memPkg::EV_OV) cause = memPkg::EXC_OV;
        else if (s1.ev == memPkg::EV_SYS) cause = memPkg::EXC_SYS;
        else if (((s1.ld == memPkg::LH || s1.ld == memPkg::LHU) && s1.addr[0])
                 || (s1.ld == memPkg::LW && s1.addr[1:0] != 2'b00)) cause = memPkg::EXC_ADEL;
        else if ((s1.st == memPkg::SH && s1.addr[0])
                 || (s1.st == memPkg::SW && s1.addr[1:0] != 2'b00)) cause = memPkg::EXC_ADES;
        else cause = memPkg::EXC_NONE;
        case (s1.sel)
            memPkg::WB_LINK: val = s1.pc + 32'd8;
            memPkg::WB_CP0:  val = cp0Val;
            memPkg::WB_LOAD: begin
                case (s1.ld)
                    memPkg::LB:  val = {{24{b[7]}}, b};
                    memPkg::LBU: val = {24'h0, b};
                    memPkg::LH:  val = {{16{h[15]}}, h};
                    memPkg::LHU: val = {16'h0, h};
                    default:     val = word;
                endcase
            end
            default: val = s1.addr;
        endcase
        // stage 2 registers at this edge, so the record is due in this cycle
        if (cause == memPkg::EXC_NONE) begin
            case (s1.st)
                memPkg::SB: modelRam[idx][8 * s1.addr[1:0] +: 8] = s1.sdata[7:0];
                memPkg::SH: modelRam[idx][16 * s1.addr[1] +: 16] = s1.sdata[15:0];
                memPkg::SW: modelRam[idx] = s1.sdata;
                default: ;
            endcase
            if (s1.regWr) begin
                wbDueQ.push_back(cyc);
                wbDstQ.push_back(s1.dst);
                wbDataQ.push_back(val);
            end
            if (s1.ev == memPkg::EV_ERET) begin
                redirDueQ.push_back(cyc);
                redirPcQ.push_back(epc);
                redirCodeQ.push_back(memPkg::EXC_NONE);
                exl = 1'b0;
            end
        end else begin
            redirDueQ.push_back(cyc);
            redirPcQ.push_back(EXC_VECTOR);
            redirCodeQ.push_back(cause);
            if (!exl) epc = s1.pc;
            exl = 1'b1;
            if (cause == memPkg::EXC_ADEL || cause == memPkg::EXC_ADES) badVAddr = s1.addr;
        end
    endtask

    // one edge: retire stage 1 in the model, shift, then drive the next instruction
    task automatic clockIn();
        @(posedge clk);
        cyc++;
        if (s1.valid && !cur.flush) modelExec();
        if (cur.valid && !cur.flush) s1 = cur;
        else s1.valid = 1'b0;
        cur = nxt;
        inValid     <= nxt.valid;
        memFlush    <= nxt.flush;
        inPc        <= nxt.pc;
        inAluOut    <= nxt.addr;
        inStoreData <= nxt.sdata;
        inLoad      <= nxt.ld;
        inStore     <= nxt.st;
        inWbSel     <= nxt.sel;
        inCp0Sel    <= nxt.cp0Sel;
        inDst       <= nxt.dst;
        inRegWr     <= nxt.regWr;
        inEvent     <= nxt.ev;
    endtask

    always @(negedge clk) begin
        if (checking) begin
            if (wbDueQ.size() > 0 && wbDueQ[0] == cyc) begin
                if (wbValid !== 1'b1) begin
                    abortRun("missing write-back: wbValid low when a result was due");
                end else begin
                    checkVal("wbDst", 32'(wbDst), 32'(wbDstQ[0]));
                    checkVal("wbData", wbData, wbDataQ[0]);
                    wbDueQ.delete(0);
                    wbDstQ.delete(0);
                    wbDataQ.delete(0);
                end
            end else if (wbValid !== 1'b0) begin
                abortRun("unexpected write-back: wbValid high with nothing due");
            end
            if (redirDueQ.size() > 0 && redirDueQ[0] == cyc) begin
                if (redirValid !== 1'b1) begin
                    abortRun("missing redirect: redirValid low when one was due");
                end else begin
                    checkVal("redirPc", redirPc, redirPcQ[0]);
                    checkVal("redirCode", 32'(redirCode), 32'(redirCodeQ[0]));
                    redirDueQ.delete(0);
                    redirPcQ.delete(0);
                    redirCodeQ.delete(0);
                end
            end else if (redirValid !== 1'b0) begin
                abortRun("unexpected redirect: redirValid high with nothing due");
            end
        end
    end

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        memFlush = 1'b0;
        inPc = '0;
        inAluOut = '0;
        inStoreData = '0;
        inLoad = memPkg::LD_NONE;
        inStore = memPkg::ST_NONE;
        inWbSel = memPkg::WB_ALU;
        inCp0Sel = 1'b0;
        inDst = '0;
        inRegWr = 1'b0;
        inEvent = memPkg::EV_NONE;
        lfsr = 32'h9622096e;
        epc = '0;
        badVAddr = '0;
        exl = 1'b0;
        checking = 1'b0;
        cyc = 0;
        cur = '0;
        s1 = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        checking = 1'b1;
        // fill the load window with word stores
        for (int i = 0; i < WIN_WORDS; i++) begin
            nxt = '0;
            nxt.valid = 1'b1;
            nxt.st = memPkg::SW;
            nxt.addr = WIN_BASE + 32'(4 * i);
            nxt.sdata = randBits(32);
            clockIn();
        end
        for (int n = 0; n < NUM_RAND; n++) begin
            genInstr();
            clockIn();
        end
        nxt = '0;
        repeat (4) clockIn();
        if (wbDueQ.size() != 0 || redirDueQ.size() != 0) begin
            abortRun("run ended with expected results that never appeared");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- hdl/dataRam.sv
/*
 * word RAM with per-lane write enables and a registered read port
 * word index is the word address modulo RAM_WORDS (RAM_WORDS >= 2)
 * read during write returns the old word, contents are not reset
 */
`timescale 1ns/1ps

module dataRam #(
    parameter int RAM_WORDS = 256
) (
    input  logic         clk,
    input  logic         wen,
    input  logic [3:0]   wstrb,
    input  logic [31:2]  addr,        // word address
    input  logic [31:0]  wdata,
    output logic [31:0]  rdata
);
    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] wordIdx;

    assign wordIdx = IDX_W'(addr % 30'(RAM_WORDS));   // wraps

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[wordIdx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read every edge, loadExtend decides whether to use it
    always_ff @(posedge clk) begin
        rdata <= mem[wordIdx];
    end

endmodule

//--- hdl/excUnit.sv
/*
 * exception decision and reduced CP0 (EPC, BadVAddr, Status.EXL)
 * decision is combinational on stage 1, redirect is registered to line up with write-back
 * no interrupts, no MTC0, a single fixed exception vector
 */
`timescale 1ns/1ps

module excUnit #(
    parameter logic [31:0] EXC_VECTOR = 32'hBFC00380
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memValid,
    input  logic [31:0]       memPc,
    input  logic [31:0]       memAddr,
    input  memPkg::loadKind   memLoad,
    input  memPkg::storeKind  memStore,
    input  memPkg::exeEvent   memEvent,
    input  logic              memCp0Sel,      // 0 EPC, 1 BadVAddr
    output logic              excTake,
    output logic [31:0]       cp0Data,
    output logic              redirValid,
    output logic [31:0]       redirPc,
    output memPkg::excCode    redirCode
);
    logic [31:0]    epc;
    logic [31:0]    badVAddr;
    logic           exl;
    logic           loadMis;
    logic           storeMis;
    logic           eretTake;
    memPkg::excCode cause;

    // halfword needs bit 0 clear, word needs both low bits clear
    assign loadMis = ((memLoad == memPkg::LH || memLoad == memPkg::LHU) && memAddr[0])
                  || (memLoad == memPkg::LW && memAddr[1:0] != 2'b00);
    assign storeMis = (memStore == memPkg::SH && memAddr[0])
                   || (memStore == memPkg::SW && memAddr[1:0] != 2'b00);

    always_comb begin
        if (memEvent == memPkg::EV_OV)        cause = memPkg::EXC_OV;   // execute events first
        else if (memEvent == memPkg::EV_SYS)  cause = memPkg::EXC_SYS;
        else if (loadMis)                     cause = memPkg::EXC_ADEL;
        else if (storeMis)                    cause = memPkg::EXC_ADES;
        else                                  cause = memPkg::EXC_NONE;
    end

    assign excTake  = memValid && (cause != memPkg::EXC_NONE);
    assign eretTake = memValid && !excTake && (memEvent == memPkg::EV_ERET);

    // regs already hold every older instruction's update
    assign cp0Data = memCp0Sel ? badVAddr : epc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epc        <= 32'h0;
            badVAddr   <= 32'h0;
            exl        <= 1'b0;
            redirValid <= 1'b0;
        end else begin
            redirValid <= excTake || eretTake;
            if (excTake) begin
                if (!exl) epc <= memPc;   // nested exception keeps first EPC
                exl <= 1'b1;
                if (cause == memPkg::EXC_ADEL || cause == memPkg::EXC_ADES) begin
                    badVAddr <= memAddr;
                end
            end else if (eretTake) begin
                exl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excTake) begin
            redirPc   <= EXC_VECTOR;
            redirCode <= cause;
        end else if (eretTake) begin
            redirPc   <= epc;             // EPC before this edge
            redirCode <= memPkg::EXC_NONE;
        end
    end

endmodule

//--- hdl/loadExtend.sv
/*
 * stage-2 register and write-back select
 * load data comes from the registered RAM read of the same edge
 */
`timescale 1ns/1ps

module loadExtend (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memValid,
    input  logic              excTake,
    input  logic              memRegWr,
    input  logic [4:0]        memDst,
    input  memPkg::wbSel      memWbSel,
    input  memPkg::loadKind   memLoad,
    input  logic [31:0]       memAddr,
    input  logic [31:0]       memPc,
    input  logic [31:0]       cp0Data,
    input  logic [31:0]       ramRdata,
    output logic              wbValid,
    output logic [4:0]        wbDst,
    output logic [31:0]       wbData
);
    memPkg::wbSel    selQ;
    memPkg::loadKind loadQ;
    logic [1:0]      laneQ;
    logic [31:0]     aluQ;
    logic [31:0]     linkQ;
    logic [31:0]     cp0Q;
    logic [7:0]      ldByte;
    logic [15:0]     ldHalf;
    logic [31:0]     ldVal;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            selQ    <= memPkg::WB_ALU;
            loadQ   <= memPkg::LD_NONE;
        end else begin
            wbValid <= memValid && memRegWr && !excTake;
            selQ    <= memWbSel;
            loadQ   <= memLoad;
        end
    end

    always_ff @(posedge clk) begin
        wbDst <= memDst;
        laneQ <= memAddr[1:0];
        aluQ  <= memAddr;
        linkQ <= memPc + 32'd8;   // skip delay slot
        cp0Q  <= cp0Data;
    end

    assign ldByte = ramRdata[8*laneQ +: 8];
    assign ldHalf = laneQ[1] ? ramRdata[31:16] : ramRdata[15:0];

    always_comb begin
        case (loadQ)
            memPkg::LB:  ldVal = {{24{ldByte[7]}}, ldByte};
            memPkg::LBU: ldVal = {24'h0, ldByte};
            memPkg::LH:  ldVal = {{16{ldHalf[15]}}, ldHalf};
            memPkg::LHU: ldVal = {16'h0, ldHalf};
            default:     ldVal = ramRdata;   // LW
        endcase
    end

    always_comb begin
        case (selQ)
            memPkg::WB_LINK: wbData = linkQ;
            memPkg::WB_LOAD: wbData = ldVal;
            memPkg::WB_CP0:  wbData = cp0Q;
            default:         wbData = aluQ;
        endcase
    end

endmodule

//--- hdl/memPkg.sv
/*
 * enums shared by the data-memory stage RTL and its testbench
 * excCode values are the MIPS Cause.ExcCode numbers
 */
package memPkg;

    // load kind carried from decode
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LB      = 3'd1,
        LBU     = 3'd2,
        LH      = 3'd3,
        LHU     = 3'd4,
        LW      = 3'd5
    } loadKind;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        SB      = 2'd1,
        SH      = 2'd2,
        SW      = 2'd3
    } storeKind;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LINK = 2'd1,     // pc + 8
        WB_LOAD = 2'd2,
        WB_CP0  = 2'd3
    } wbSel;

    // events already resolved in execute
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_OV   = 2'd1,
        EV_SYS  = 2'd2,
        EV_ERET = 2'd3
    } exeEvent;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_OV   = 5'd12
    } excCode;

endpackage

//--- hdl/memReg.sv
/*
 * stage-1 register, one instruction per inValid strobe, no back-pressure
 * memFlush also kills the instruction currently held, so memValid drops at once
 */
`timescale 1ns/1ps

module memReg (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memFlush,
    input  logic              inValid,
    input  logic [31:0]       inPc,
    input  logic [31:0]       inAluOut,
    input  logic [31:0]       inStoreData,
    input  memPkg::loadKind   inLoad,
    input  memPkg::storeKind  inStore,
    input  memPkg::wbSel      inWbSel,
    input  logic              inCp0Sel,
    input  logic [4:0]        inDst,
    input  logic              inRegWr,
    input  memPkg::exeEvent   inEvent,
    output logic              memValid,
    output logic [31:0]       memPc,
    output logic [31:0]       memAddr,
    output logic [31:0]       memStoreData,
    output memPkg::loadKind   memLoad,
    output memPkg::storeKind  memStore,
    output memPkg::wbSel      memWbSel,
    output logic              memCp0Sel,
    output logic [4:0]        memDst,
    output logic              memRegWr,
    output memPkg::exeEvent   memEvent
);
    logic validQ;
    logic take;

    assign take     = inValid && !memFlush;   // flush wins over a new strobe
    assign memValid = validQ && !memFlush;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ   <= 1'b0;
            memLoad  <= memPkg::LD_NONE;
            memStore <= memPkg::ST_NONE;
            memWbSel <= memPkg::WB_ALU;
            memEvent <= memPkg::EV_NONE;
        end else begin
            validQ <= take;
            if (take) begin
                memLoad  <= inLoad;
                memStore <= inStore;
                memWbSel <= inWbSel;
                memEvent <= inEvent;
            end
        end
    end

    // payload holds its value between strobes
    always_ff @(posedge clk) begin
        if (take) begin
            memPc        <= inPc;
            memAddr      <= inAluOut;
            memStoreData <= inStoreData;
            memCp0Sel    <= inCp0Sel;
            memDst       <= inDst;
            memRegWr     <= inRegWr;
        end
    end

endmodule

//--- hdl/memTop.sv
/*
 * data-memory stage, capture then access/write-back
 * results and redirects appear two edges after the strobe, no back-pressure
 */
`timescale 1ns/1ps

module memTop #(
    parameter int          RAM_WORDS  = 256,
    parameter logic [31:0] EXC_VECTOR = 32'hBFC00380
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  logic [31:0]       inPc,
    input  logic [31:0]       inAluOut,
    input  logic [31:0]       inStoreData,
    input  memPkg::loadKind   inLoad,
    input  memPkg::storeKind  inStore,
    input  memPkg::wbSel      inWbSel,
    input  logic              inCp0Sel,
    input  logic [4:0]        inDst,
    input  logic              inRegWr,
    input  memPkg::exeEvent   inEvent,
    input  logic              memFlush,
    output logic              wbValid,
    output logic [4:0]        wbDst,
    output logic [31:0]       wbData,
    output logic              redirValid,
    output logic [31:0]       redirPc,
    output memPkg::excCode    redirCode
);
    logic              memValid;
    logic [31:0]       memPc, memAddr, memStoreData;
    memPkg::loadKind   memLoad;
    memPkg::storeKind  memStore;
    memPkg::wbSel      memWbSel;
    logic              memCp0Sel, memRegWr;
    logic [4:0]        memDst;
    memPkg::exeEvent   memEvent;
    logic [3:0]        ramWstrb;
    logic [31:0]       ramWdata, ramRdata, cp0Data;
    logic              ramWen, excTake;

    assign ramWen = memValid && !excTake && (ramWstrb != 4'b0000);   // excepting store never lands

    memReg u_memReg (
        .clk(clk), .rstN(rstN), .memFlush(memFlush), .inValid(inValid),
        .inPc(inPc), .inAluOut(inAluOut), .inStoreData(inStoreData),
        .inLoad(inLoad), .inStore(inStore), .inWbSel(inWbSel), .inCp0Sel(inCp0Sel),
        .inDst(inDst), .inRegWr(inRegWr), .inEvent(inEvent),
        .memValid(memValid), .memPc(memPc), .memAddr(memAddr),
        .memStoreData(memStoreData), .memLoad(memLoad), .memStore(memStore),
        .memWbSel(memWbSel), .memCp0Sel(memCp0Sel), .memDst(memDst),
        .memRegWr(memRegWr), .memEvent(memEvent)
    );

    storeAlign u_storeAlign (
        .memStore(memStore), .memAddr(memAddr[1:0]), .memStoreData(memStoreData),
        .ramWstrb(ramWstrb), .ramWdata(ramWdata)
    );

    dataRam #(.RAM_WORDS(RAM_WORDS)) u_dataRam (
        .clk(clk), .wen(ramWen), .wstrb(ramWstrb), .addr(memAddr[31:2]),
        .wdata(ramWdata), .rdata(ramRdata)
    );

    excUnit #(.EXC_VECTOR(EXC_VECTOR)) u_excUnit (
        .clk(clk), .rstN(rstN), .memValid(memValid), .memPc(memPc), .memAddr(memAddr),
        .memLoad(memLoad), .memStore(memStore), .memEvent(memEvent),
        .memCp0Sel(memCp0Sel), .excTake(excTake), .cp0Data(cp0Data),
        .redirValid(redirValid), .redirPc(redirPc), .redirCode(redirCode)
    );

    loadExtend u_loadExtend (
        .clk(clk), .rstN(rstN), .memValid(memValid), .excTake(excTake),
        .memRegWr(memRegWr), .memDst(memDst), .memWbSel(memWbSel), .memLoad(memLoad),
        .memAddr(memAddr), .memPc(memPc), .cp0Data(cp0Data), .ramRdata(ramRdata),
        .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData)
    );

endmodule

//--- hdl/storeAlign.sv
/*
 * little-endian byte-lane steering for stores
 * no alignment check here, a misaligned SH/SW is caught in excUnit
 */
`timescale 1ns/1ps

module storeAlign (
    input  memPkg::storeKind  memStore,
    input  logic [1:0]        memAddr,        // low address bits only
    input  logic [31:0]       memStoreData,
    output logic [3:0]        ramWstrb,
    output logic [31:0]       ramWdata
);

    always_comb begin
        case (memStore)
            memPkg::SB: begin
                ramWdata = {4{memStoreData[7:0]}};    // byte on every lane
                ramWstrb = 4'b0001 << memAddr;
            end
            memPkg::SH: begin
                ramWdata = {2{memStoreData[15:0]}};
                ramWstrb = memAddr[1] ? 4'b1100 : 4'b0011;
            end
            memPkg::SW: begin
                ramWdata = memStoreData;
                ramWstrb = 4'b1111;
            end
            default: begin
                // not a store
                ramWdata = memStoreData;
                ramWstrb = 4'b0000;
            end
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# build tbMem with Verilator, run it, and fail on a FAIL line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tbMem -f all.f -o simTb
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "build failed with status $buildStatus"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "simulator exited with status $runStatus"
    exit 1
fi

echo "simulation passed"
exit 0
